// ==== Makefile ====
# Verilator build and run of the data cache testbench

SIM := obj_dir/tb_dcache

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): project.f *.sv *.svh
	verilator --binary --assert --timing --timescale 1ns/1ps -f project.f \
		--top-module tb_dcache --Mdir obj_dir -o tb_dcache

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== dcache_cfg_regs.sv ====
/*
 Configuration registers of the data cache
 Wishbone classic slave with the set invalidate register
 Saturating read miss counter, cleared by a write
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_cfg_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cfg_cyc_i,
   input  logic                   cfg_stb_i,
   input  logic                   cfg_we_i,
   input  logic [`DC_ADDR_W-1:0]  cfg_adr_i,
   input  logic [`DC_DATA_W-1:0]  cfg_dat_i,
   output logic [`DC_DATA_W-1:0]  cfg_dat_o,
   output logic                   cfg_ack_o,
   output dcache_pkg::inval_req_t inval_o,
   input  logic                   inval_done_i,
   input  logic                   miss_event_i
);

   logic [`DC_MISS_W-1:0] miss_cnt_q;
   logic                  access;
   logic                  sel_inval;
   logic                  sel_miss;

   // New access only when no ack or invalidate is outstanding
   assign access    = cfg_cyc_i && cfg_stb_i && !cfg_ack_o && !inval_o.valid;
   assign sel_inval = (cfg_adr_i == `DC_CFG_INVAL_OFS);
   assign sel_miss  = (cfg_adr_i == `DC_CFG_MISS_OFS);

   always_ff @(posedge clk) begin
      if (rst) begin
         cfg_ack_o  <= 1'b0;
         inval_o    <= '0;
         miss_cnt_q <= '0;
      end else begin
         cfg_ack_o <= 1'b0;
         if (inval_done_i) begin
            inval_o.valid <= 1'b0;
            cfg_ack_o     <= 1'b1;
         end else if (access && cfg_we_i && sel_inval) begin
            // Set index taken from the written address
            inval_o.valid <= 1'b1;
            inval_o.set   <= cfg_dat_i[`DC_BLOCK_W +: `DC_SET_W];
         end else if (access) begin
            cfg_ack_o <= 1'b1;
         end
         // Clear by write, else count up and stick at the top
         if (access && cfg_we_i && sel_miss) begin
            miss_cnt_q <= '0;
         end else if (miss_event_i && miss_cnt_q != '1) begin
            miss_cnt_q <= miss_cnt_q + 1'b1;
         end
      end
   end

   // Unmapped reads return zero
   always_ff @(posedge clk) begin
      if (access) begin
         cfg_dat_o <= sel_miss ? {{(`DC_DATA_W-`DC_MISS_W){1'b0}}, miss_cnt_q} : '0;
      end
   end

   a_ack_stb: assert property (@(posedge clk) disable iff (rst) cfg_ack_o |-> cfg_stb_i)
      else $error("FAIL cfg_ack_o without cfg_stb_i, adr 0x%h", cfg_adr_i);

endmodule

// ==== dcache_ctrl.sv ====
/*
 Data cache controller
 Lookup, hit and miss handling, victim choice and refill
 Write-through over a Wishbone classic master
 Set invalidation from the register block
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl (
   input  logic                        clk,
   input  logic                        rst,
   input  dcache_pkg::cpu_req_t        cpu_req_i,
   input  logic                        cpu_valid_i,
   output logic                        cpu_ack_o,
   output logic [`DC_DATA_W-1:0]       cpu_rdata_o,
   output dcache_pkg::wb_req_t         mem_o,
   input  logic                        mem_ack_i,
   input  logic [`DC_DATA_W-1:0]       mem_dat_i,
   input  dcache_pkg::inval_req_t      inval_i,
   output logic                        inval_done_o,
   output logic                        miss_event_o,
   output logic [`DC_SET_W-1:0]        tag_rd_set_o,
   input  dcache_pkg::tag_set_t        tag_rd_data_i,
   output logic                        tag_wr_en_o,
   output logic [`DC_SET_W-1:0]        tag_wr_set_o,
   output dcache_pkg::tag_set_t        tag_wr_data_o,
   output logic [`DC_RAM_ADR_W-1:0]    data_rd_adr_o,
   input  logic [1:0][`DC_DATA_W-1:0]  data_rd_data_i,
   output logic                        data_wr_way_o,
   output logic                        data_wr_en_o,
   output logic [`DC_SEL_W-1:0]        data_wr_sel_o,
   output logic [`DC_RAM_ADR_W-1:0]    data_wr_adr_o,
   output logic [`DC_DATA_W-1:0]       data_wr_data_o
);

   dcache_pkg::ctrl_state_e state_q;
   // Refill beat counter wrapping to zero after the last word
   logic [`DC_WORD_W-1:0]   beat_q;
   logic                    victim_q;
   logic [`DC_DATA_W-1:0]   rdata_q;

   logic [`DC_SET_W-1:0]    req_set;
   logic [`DC_WORD_W-1:0]   req_word;
   logic [`DC_TAG_W-1:0]    req_tag;
   logic [1:0]              way_hit;
   logic                    hit;
   logic                    hit_way;
   logic                    victim;

   // Address fields of the held request
   assign req_set  = cpu_req_i.adr[`DC_BLOCK_W +: `DC_SET_W];
   assign req_word = cpu_req_i.adr[2 +: `DC_WORD_W];
   assign req_tag  = cpu_req_i.adr[`DC_ADDR_W-1 -: `DC_TAG_W];

   // Memories read from the held request every cycle
   assign tag_rd_set_o  = req_set;
   assign data_rd_adr_o = {req_set, req_word};

   // Tag compare result valid in LOOKUP
   always_comb begin
      for (int w = 0; w < 2; w++) begin
         way_hit[w] = tag_rd_data_i.way[w].valid && (tag_rd_data_i.way[w].tag == req_tag);
      end
   end
   assign hit     = |way_hit;
   assign hit_way = way_hit[1];

   // Victim is the first invalid way or else the LRU way
   assign victim = !tag_rd_data_i.way[0].valid ? 1'b0 :
                   !tag_rd_data_i.way[1].valid ? 1'b1 : tag_rd_data_i.lru;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q  <= dcache_pkg::IDLE;
         beat_q   <= '0;
         victim_q <= 1'b0;
      end else begin
         case (state_q)
            dcache_pkg::IDLE: begin
               // Invalidate wins over a CPU request
               if (inval_i.valid) begin
                  state_q <= dcache_pkg::INVAL;
               end else if (cpu_valid_i) begin
                  state_q <= dcache_pkg::LOOKUP;
               end
            end
            dcache_pkg::LOOKUP: begin
               if (cpu_req_i.we) begin
                  state_q <= dcache_pkg::WRITE_MEM;
               end else if (hit) begin
                  state_q <= dcache_pkg::HIT_DONE;
               end else begin
                  state_q  <= dcache_pkg::REFILL;
                  victim_q <= victim;
               end
            end
            dcache_pkg::REFILL: begin
               if (mem_ack_i) begin
                  beat_q <= beat_q + 1'b1;
                  if (beat_q == '1) begin
                     state_q <= dcache_pkg::HIT_DONE;
                  end
               end
            end
            dcache_pkg::WRITE_MEM: begin
               if (mem_ack_i) begin
                  state_q <= dcache_pkg::HIT_DONE;
               end
            end
            default: state_q <= dcache_pkg::IDLE;
         endcase
      end
   end

   // Read data for the ack from the hit way or the matching refill beat
   always_ff @(posedge clk) begin
      if (state_q == dcache_pkg::LOOKUP) begin
         rdata_q <= data_rd_data_i[hit_way];
      end else if (state_q == dcache_pkg::REFILL && mem_ack_i && beat_q == req_word) begin
         rdata_q <= mem_dat_i;
      end
   end

   always_comb begin
      tag_wr_en_o    = 1'b0;
      tag_wr_set_o   = req_set;
      tag_wr_data_o  = tag_rd_data_i;
      data_wr_en_o   = 1'b0;
      data_wr_way_o  = hit_way;
      data_wr_sel_o  = cpu_req_i.sel;
      data_wr_adr_o  = {req_set, req_word};
      data_wr_data_o = cpu_req_i.wdata;
      mem_o          = '0;
      case (state_q)
         dcache_pkg::LOOKUP: begin
            // Hit moves the LRU to the other way
            // Write hit merges the byte lanes
            if (hit) begin
               tag_wr_en_o       = 1'b1;
               tag_wr_data_o.lru = ~hit_way;
               data_wr_en_o      = cpu_req_i.we;
            end
         end
         dcache_pkg::REFILL: begin
            mem_o.cyc      = 1'b1;
            mem_o.stb      = 1'b1;
            mem_o.adr      = {cpu_req_i.adr[`DC_ADDR_W-1:`DC_BLOCK_W], beat_q, 2'b00};
            mem_o.sel      = '1;
            data_wr_en_o   = mem_ack_i;
            data_wr_way_o  = victim_q;
            data_wr_sel_o  = '1;
            data_wr_adr_o  = {req_set, beat_q};
            data_wr_data_o = mem_dat_i;
            // Last beat makes the victim valid with the new tag
            if (mem_ack_i && beat_q == '1) begin
               tag_wr_en_o                      = 1'b1;
               tag_wr_data_o.way[victim_q].valid = 1'b1;
               tag_wr_data_o.way[victim_q].tag   = req_tag;
               tag_wr_data_o.lru                 = ~victim_q;
            end
         end
         dcache_pkg::WRITE_MEM: begin
            mem_o = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: cpu_req_i.adr,
                      dat: cpu_req_i.wdata, sel: cpu_req_i.sel};
         end
         dcache_pkg::INVAL: begin
            tag_wr_en_o   = 1'b1;
            tag_wr_set_o  = inval_i.set;
            tag_wr_data_o = '0;
         end
         default: ;
      endcase
   end

   assign cpu_ack_o    = (state_q == dcache_pkg::HIT_DONE);
   assign cpu_rdata_o  = rdata_q;
   assign inval_done_o = (state_q == dcache_pkg::INVAL);
   assign miss_event_o = (state_q == dcache_pkg::LOOKUP) && !hit && !cpu_req_i.we;

   // A strobe stays up with cyc and its address until the slave acks
   a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
      (mem_o.stb && !mem_ack_i) |=> (mem_o.cyc && mem_o.stb && $stable(mem_o.adr)))
      else $error("FAIL mem_o.stb or mem_o.adr changed before ack, adr 0x%h", mem_o.adr);
   a_ack_valid: assert property (@(posedge clk) disable iff (rst) cpu_ack_o |-> cpu_valid_i)
      else $error("FAIL cpu_ack_o without cpu_valid_i, adr 0x%h", cpu_req_i.adr);
   // A tag write never leaves one tag valid in both ways of a set
   a_tag_unique: assert property (@(posedge clk) disable iff (rst)
      tag_wr_en_o |-> !(tag_wr_data_o.way[0].valid && tag_wr_data_o.way[1].valid &&
                        tag_wr_data_o.way[0].tag == tag_wr_data_o.way[1].tag))
      else $error("FAIL tag_wr_data_o tag 0x%h in both ways, set 0x%h",
         tag_wr_data_o.way[0].tag, tag_wr_set_o);

endmodule

// ==== dcache_data_ram.sv ====
/*
 Data store of the two way data cache
 Both ways read in parallel with one cycle latency
 Writes go to one way with byte lane enables
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_data_ram (
   input  logic                        clk,
   input  logic [`DC_RAM_ADR_W-1:0]    rd_adr_i,
   output logic [1:0][`DC_DATA_W-1:0]  rd_data_o,
   input  logic                        wr_way_i,
   input  logic                        wr_en_i,
   input  logic [`DC_SEL_W-1:0]        wr_sel_i,
   input  logic [`DC_RAM_ADR_W-1:0]    wr_adr_i,
   input  logic [`DC_DATA_W-1:0]       wr_data_i
);

   // One word array per way
   logic [`DC_DATA_W-1:0] way_mem [2][2**`DC_RAM_ADR_W];

   // Byte lane write into the selected way
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         for (int b = 0; b < `DC_SEL_W; b++) begin
            if (wr_sel_i[b]) begin
               way_mem[wr_way_i][wr_adr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
            end
         end
      end
   end

   // Registered read of both ways, hit way picked by the controller
   always_ff @(posedge clk) begin
      for (int w = 0; w < 2; w++) begin
         rd_data_o[w] <= way_mem[w][rd_adr_i];
      end
   end

endmodule

// ==== dcache_pkg.sv ====
/*
 Shared types of the data cache
 Controller states, CPU request, tag entries and tag set
 Wishbone master request and invalidate request
*/
`include "dcache_settings.svh"

package dcache_pkg;

   // Controller FSM states
   typedef enum logic [2:0] {
      IDLE      = 3'd0,
      LOOKUP    = 3'd1,
      REFILL    = 3'd2,
      WRITE_MEM = 3'd3,
      INVAL     = 3'd4,
      HIT_DONE  = 3'd5
   } ctrl_state_e;

   // Held by the CPU until acknowledged
   typedef struct packed {
      logic [`DC_ADDR_W-1:0] adr;
      logic [`DC_DATA_W-1:0] wdata;
      logic                  we;
      logic [`DC_SEL_W-1:0]  sel;
   } cpu_req_t;

   typedef struct packed {
      logic                 valid;
      logic [`DC_TAG_W-1:0] tag;
   } tag_entry_t;

   // One set: both ways plus the LRU bit
   // lru names the least recently used way
   typedef struct packed {
      tag_entry_t [1:0] way;
      logic             lru;
   } tag_set_t;

   // Wishbone classic master outputs
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [`DC_ADDR_W-1:0] adr;
      logic [`DC_DATA_W-1:0] dat;
      logic [`DC_SEL_W-1:0]  sel;
   } wb_req_t;

   // Register block to controller
   typedef struct packed {
      logic                 valid;
      logic [`DC_SET_W-1:0] set;
   } inval_req_t;

endpackage

// ==== dcache_settings.svh ====
/*
 Widths for the data cache
 Address, data, byte select, block, set and tag fields
 Configuration register offsets and miss counter width
*/
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Bus widths
`define DC_ADDR_W 32
`define DC_DATA_W 32
`define DC_SEL_W 4
// Sixteen byte blocks, four words each
`define DC_BLOCK_W 4
`define DC_WORD_W (`DC_BLOCK_W - 2)
// 64 sets
`define DC_SET_W 6
`define DC_TAG_W (`DC_ADDR_W - `DC_SET_W - `DC_BLOCK_W)
// Word address into one way of the data memory
`define DC_RAM_ADR_W (`DC_SET_W + `DC_WORD_W)
// Configuration registers
`define DC_CFG_INVAL_OFS 0
`define DC_CFG_MISS_OFS 4
`define DC_MISS_W 16
`endif

// ==== dcache_tag_ram.sv ====
/*
 Tag store of the two way data cache
 One tag set per set index, synchronous read, one write port
 Valid bits in a separate array that reset clears
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_ram (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [`DC_SET_W-1:0] rd_set_i,
   output dcache_pkg::tag_set_t rd_data_o,
   input  logic                 wr_en_i,
   input  logic [`DC_SET_W-1:0] wr_set_i,
   input  dcache_pkg::tag_set_t wr_data_i
);

   // Tags and LRU bits
   dcache_pkg::tag_set_t tag_mem [2**`DC_SET_W];
   // Valid bits with way 1 in bit 1
   logic [1:0] valid_q [2**`DC_SET_W];

   dcache_pkg::tag_set_t rd_tag_q;
   logic [1:0]           rd_valid_q;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         tag_mem[wr_set_i] <= wr_data_i;
      end
      rd_tag_q <= tag_mem[rd_set_i];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < 2**`DC_SET_W; s++) begin
            valid_q[s] <= 2'b00;
         end
         rd_valid_q <= 2'b00;
      end else begin
         if (wr_en_i) begin
            valid_q[wr_set_i] <= {wr_data_i.way[1].valid, wr_data_i.way[0].valid};
         end
         // A read in the cycle of a write returns the old valid bits
         rd_valid_q <= valid_q[rd_set_i];
      end
   end

   // Stored tags with the valid bits from the resettable array
   always_comb begin
      rd_data_o = rd_tag_q;
      rd_data_o.way[0].valid = rd_valid_q[0];
      rd_data_o.way[1].valid = rd_valid_q[1];
   end

   // The controller must stay quiet while reset clears the valid bits
   a_no_wr_in_rst: assert property (@(posedge clk) rst |-> !wr_en_i)
      else $error("FAIL wr_en_i high during reset, set 0x%h", wr_set_i);

endmodule

// ==== dcache_top.sv ====
/*
 Two way set associative data cache, top level
 Controller, tag and data memories, configuration registers
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
   input  logic                  clk,
   input  logic                  rst,
   input  dcache_pkg::cpu_req_t  cpu_req_i,
   input  logic                  cpu_valid_i,
   output logic                  cpu_ack_o,
   output logic [`DC_DATA_W-1:0] cpu_rdata_o,
   output dcache_pkg::wb_req_t   mem_o,
   input  logic                  mem_ack_i,
   input  logic [`DC_DATA_W-1:0] mem_dat_i,
   input  logic                  cfg_cyc_i,
   input  logic                  cfg_stb_i,
   input  logic                  cfg_we_i,
   input  logic [`DC_ADDR_W-1:0] cfg_adr_i,
   input  logic [`DC_DATA_W-1:0] cfg_dat_i,
   output logic [`DC_DATA_W-1:0] cfg_dat_o,
   output logic                  cfg_ack_o
);

   // Tag memory port
   logic [`DC_SET_W-1:0]       tag_rd_set;
   dcache_pkg::tag_set_t       tag_rd_data;
   logic                       tag_wr_en;
   logic [`DC_SET_W-1:0]       tag_wr_set;
   dcache_pkg::tag_set_t       tag_wr_data;
   // Data memory port
   logic [`DC_RAM_ADR_W-1:0]   data_rd_adr;
   logic [1:0][`DC_DATA_W-1:0] data_rd_data;
   logic                       data_wr_way;
   logic                       data_wr_en;
   logic [`DC_SEL_W-1:0]       data_wr_sel;
   logic [`DC_RAM_ADR_W-1:0]   data_wr_adr;
   logic [`DC_DATA_W-1:0]      data_wr_data;
   // Register block to controller
   dcache_pkg::inval_req_t     inval;
   logic                       inval_done;
   logic                       miss_event;

   dcache_ctrl u_ctrl (
      .clk, .rst, .cpu_req_i, .cpu_valid_i, .cpu_ack_o, .cpu_rdata_o,
      .mem_o, .mem_ack_i, .mem_dat_i,
      .inval_i(inval), .inval_done_o(inval_done), .miss_event_o(miss_event),
      .tag_rd_set_o(tag_rd_set), .tag_rd_data_i(tag_rd_data), .tag_wr_en_o(tag_wr_en),
      .tag_wr_set_o(tag_wr_set), .tag_wr_data_o(tag_wr_data),
      .data_rd_adr_o(data_rd_adr), .data_rd_data_i(data_rd_data),
      .data_wr_way_o(data_wr_way), .data_wr_en_o(data_wr_en), .data_wr_sel_o(data_wr_sel),
      .data_wr_adr_o(data_wr_adr), .data_wr_data_o(data_wr_data)
   );

   dcache_tag_ram u_tag_ram (
      .clk, .rst, .rd_set_i(tag_rd_set), .rd_data_o(tag_rd_data),
      .wr_en_i(tag_wr_en), .wr_set_i(tag_wr_set), .wr_data_i(tag_wr_data)
   );

   dcache_data_ram u_data_ram (
      .clk, .rd_adr_i(data_rd_adr), .rd_data_o(data_rd_data), .wr_way_i(data_wr_way),
      .wr_en_i(data_wr_en), .wr_sel_i(data_wr_sel), .wr_adr_i(data_wr_adr),
      .wr_data_i(data_wr_data)
   );

   dcache_cfg_regs u_cfg_regs (
      .clk, .rst, .cfg_cyc_i, .cfg_stb_i, .cfg_we_i, .cfg_adr_i, .cfg_dat_i,
      .cfg_dat_o, .cfg_ack_o, .inval_o(inval), .inval_done_i(inval_done),
      .miss_event_i(miss_event)
   );

endmodule

// ==== project.f ====
+incdir+.
dcache_pkg.sv
dcache_tag_ram.sv
dcache_data_ram.sv
dcache_ctrl.sv
dcache_cfg_regs.sv
dcache_top.sv
tb_dcache.sv

// ==== tb_dcache.sv ====
/*
 Testbench for the two way data cache
 Clock, reset, CPU driver and configuration bus driver
 Wishbone memory model with random ack delay
 Tag and LRU model of the cache, checking assertions
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache;

   localparam int MEM_WORDS = 4096;
   localparam int TIMEOUT   = 200;

   logic                  clk;
   logic                  rst;
   dcache_pkg::cpu_req_t  cpu_req;
   logic                  cpu_valid;
   logic                  cpu_ack;
   logic [`DC_DATA_W-1:0] cpu_rdata;
   dcache_pkg::wb_req_t   mem_req;
   logic                  mem_ack;
   logic [`DC_DATA_W-1:0] mem_dat;
   logic                  cfg_cyc;
   logic                  cfg_stb;
   logic                  cfg_we;
   logic [`DC_ADDR_W-1:0] cfg_adr;
   logic [`DC_DATA_W-1:0] cfg_wdat;
   logic [`DC_DATA_W-1:0] cfg_rdat;
   logic                  cfg_ack;

   // LCG state, shared by memory fill, ack delay and random requests
   logic [31:0]           seed = 32'd31995;
   // 16 KB of model memory, word index from address bits 13:2
   logic [`DC_DATA_W-1:0] mem_word [MEM_WORDS];
   int                    mem_cycles;
   int                    mem_reads;
   // Expectations for the request in flight
   int                    cycle_cnt = 0;
   int                    req_start;
   int                    base_cycles;
   int                    exp_cycles;
   int                    reads_at_clear;
   logic [`DC_DATA_W-1:0] merge_expect;
   logic [`DC_DATA_W-1:0] cur_word;
   logic [`DC_DATA_W-1:0] exp_misses;
   // Valid bits, tags and LRU bit per set, as the cache should hold them
   logic [1:0]            m_valid [2**`DC_SET_W];
   logic [`DC_TAG_W-1:0]  m_tag [2**`DC_SET_W][2];
   logic                  m_lru [2**`DC_SET_W];

   dcache_top DUT (
      .clk, .rst, .cpu_req_i(cpu_req), .cpu_valid_i(cpu_valid), .cpu_ack_o(cpu_ack),
      .cpu_rdata_o(cpu_rdata), .mem_o(mem_req), .mem_ack_i(mem_ack), .mem_dat_i(mem_dat),
      .cfg_cyc_i(cfg_cyc), .cfg_stb_i(cfg_stb), .cfg_we_i(cfg_we), .cfg_adr_i(cfg_adr),
      .cfg_dat_i(cfg_wdat), .cfg_dat_o(cfg_rdat), .cfg_ack_o(cfg_ack)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Rising edge count, for the hit latency
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   assign cur_word   = mem_word[cpu_req.adr[13:2]];
   assign exp_misses = 32'((mem_reads - reads_at_clear) / 4);

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "Stopped at the first error");
   endtask

   // Wishbone slave memory, one transfer per ack
   initial begin
      logic [31:0] rnd;
      logic [11:0] idx;
      int          delay;
      mem_ack    = 1'b0;
      mem_dat    = '0;
      mem_cycles = 0;
      mem_reads  = 0;
      delay      = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_word[i] = next_rand() ^ (32'(i) << 2);
      end
      forever begin
         @(negedge clk);
         mem_ack = 1'b0;
         if (!rst && mem_req.cyc && mem_req.stb) begin
            if (delay > 0) begin
               delay--;
            end else begin
               idx = mem_req.adr[13:2];
               if (mem_req.we) begin
                  for (int b = 0; b < `DC_SEL_W; b++) begin
                     if (mem_req.sel[b]) begin
                        mem_word[idx][8*b +: 8] = mem_req.dat[8*b +: 8];
                     end
                  end
               end else begin
                  mem_dat = mem_word[idx];
                  mem_reads++;
               end
               mem_ack = 1'b1;
               mem_cycles++;
               // Wait of 0 to 3 cycles before the next ack
               rnd   = next_rand();
               delay = int'(rnd[17:16]);
            end
         end
      end
   end

   // Expected bus cycles of one access: hit, refill into the victim, or write-through
   task automatic predict_access(input logic [31:0] adr, input logic we);
      logic [`DC_SET_W-1:0] set_idx;
      logic [`DC_TAG_W-1:0] tag;
      logic                 victim;
      int                   hit_way;
      set_idx = adr[`DC_BLOCK_W +: `DC_SET_W];
      tag     = adr[`DC_ADDR_W-1 -: `DC_TAG_W];
      hit_way = -1;
      for (int w = 0; w < 2; w++) begin
         if (m_valid[set_idx][w] && m_tag[set_idx][w] == tag) begin
            hit_way = w;
         end
      end
      if (hit_way >= 0) begin
         // Any hit leaves the other way as the LRU one
         m_lru[set_idx] = (hit_way == 0);
         exp_cycles = we ? 1 : 0;
      end else if (we) begin
         // No allocate on a write miss
         exp_cycles = 1;
      end else begin
         victim = !m_valid[set_idx][0] ? 1'b0 : !m_valid[set_idx][1] ? 1'b1 : m_lru[set_idx];
         m_valid[set_idx][victim] = 1'b1;
         m_tag[set_idx][victim]   = tag;
         m_lru[set_idx]           = !victim;
         exp_cycles = 4;
      end
   endtask

   task automatic cpu_access(input logic [31:0] adr, input logic we,
                             input logic [31:0] wdata, input logic [3:0] sel);
      logic [31:0] mask;
      int          waited;
      predict_access(adr, we);
      for (int b = 0; b < 4; b++) begin
         mask[8*b +: 8] = {8{sel[b]}};
      end
      // Word that memory must hold after the write-through
      merge_expect  = (mem_word[adr[13:2]] & ~mask) | (wdata & mask);
      base_cycles   = mem_cycles;
      req_start     = cycle_cnt;
      cpu_req.adr   = adr;
      cpu_req.wdata = wdata;
      cpu_req.we    = we;
      cpu_req.sel   = sel;
      cpu_valid     = 1'b1;
      waited = 0;
      while (!cpu_ack && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!cpu_ack) begin
         stop_on_error("CPU request got no acknowledge within the timeout");
      end
      // Ack is taken at the rising edge in between
      @(negedge clk);
      cpu_valid = 1'b0;
   endtask

   task automatic cfg_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat);
      int waited;
      if (we && adr == `DC_CFG_MISS_OFS) begin
         reads_at_clear = mem_reads;
      end
      if (we && adr == `DC_CFG_INVAL_OFS) begin
         m_valid[wdat[`DC_BLOCK_W +: `DC_SET_W]] = 2'b00;
      end
      cfg_cyc  = 1'b1;
      cfg_stb  = 1'b1;
      cfg_we   = we;
      cfg_adr  = adr;
      cfg_wdat = wdat;
      waited = 0;
      while (!cfg_ack && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!cfg_ack) begin
         stop_on_error("Configuration access got no acknowledge within the timeout");
      end
      @(negedge clk);
      cfg_cyc = 1'b0;
      cfg_stb = 1'b0;
      cfg_we  = 1'b0;
   endtask

   // Reads return the current memory word, hit or miss
   a_read_data: assert property (@(posedge clk) disable iff (rst)
      (cpu_ack && !cpu_req.we) |-> cpu_rdata == cur_word)
      else stop_on_error($sformatf("FAIL cpu_rdata_o 0x%h, expected 0x%h at 0x%h",
         $sampled(cpu_rdata), $sampled(cur_word), $sampled(cpu_req.adr)));
   // No bus cycle on a read hit, four on a refill, one on a write
   a_mem_traffic: assert property (@(posedge clk) disable iff (rst)
      cpu_ack |-> (mem_cycles - base_cycles) == exp_cycles)
      else stop_on_error($sformatf("FAIL mem_o cycle count 0x%h, expected 0x%h at 0x%h",
         $sampled(mem_cycles) - $sampled(base_cycles), $sampled(exp_cycles),
         $sampled(cpu_req.adr)));
   a_hit_latency: assert property (@(posedge clk) disable iff (rst)
      (cpu_ack && exp_cycles == 0) |-> (cycle_cnt - req_start) == 2)
      else stop_on_error($sformatf("FAIL cpu_ack_o latency 0x%h, expected 0x2",
         $sampled(cycle_cnt) - $sampled(req_start)));
   // Memory holds the byte lane merge once the write is acked
   a_write_merge: assert property (@(posedge clk) disable iff (rst)
      (cpu_ack && cpu_req.we) |-> cur_word == merge_expect)
      else stop_on_error($sformatf("FAIL mem_o.dat merged word 0x%h, expected 0x%h",
         $sampled(cur_word), $sampled(merge_expect)));
   a_miss_count: assert property (@(posedge clk) disable iff (rst)
      (cfg_ack && !cfg_we && cfg_adr == `DC_CFG_MISS_OFS) |-> cfg_rdat == exp_misses)
      else stop_on_error($sformatf("FAIL cfg_dat_o 0x%h, expected 0x%h",
         $sampled(cfg_rdat), $sampled(exp_misses)));

   initial begin
      logic [31:0] rnd;
      logic [31:0] adr;
      rst            = 1'b1;
      cpu_valid      = 1'b0;
      cpu_req        = '0;
      cfg_cyc        = 1'b0;
      cfg_stb        = 1'b0;
      cfg_we         = 1'b0;
      cfg_adr        = '0;
      cfg_wdat       = '0;
      reads_at_clear = 0;
      exp_cycles     = 0;
      base_cycles    = 0;
      req_start      = 0;
      merge_expect   = '0;
      for (int s = 0; s < 2**`DC_SET_W; s++) begin
         m_valid[s] = 2'b00;
         m_lru[s]   = 1'b0;
      end
      repeat (10) @(negedge clk);
      rst = 1'b0;
      // Refill on word 0, then each word of the block hits
      for (int w = 0; w < 5; w++) begin
         cpu_access(32'h40 + 32'((w % 4) * 4), 1'b0, '0, '0);
      end
      // Partial write on a hit, then on a miss, each read back
      cpu_access(32'h44, 1'b1, 32'hA5A5_5A5A, 4'b0101);
      cpu_access(32'h44, 1'b0, '0, '0);
      cpu_access(32'h1234, 1'b1, 32'h1357_9BDF, 4'b1100);
      cpu_access(32'h1234, 1'b0, '0, '0);
      // Set 8: A, B, A, C evicts B, then A hits and B refills
      cpu_access(32'h0080, 1'b0, '0, '0);
      cpu_access(32'h0480, 1'b0, '0, '0);
      cpu_access(32'h0080, 1'b0, '0, '0);
      cpu_access(32'h0880, 1'b0, '0, '0);
      cpu_access(32'h0084, 1'b0, '0, '0);
      cpu_access(32'h0480, 1'b0, '0, '0);
      // Random traffic over 16 tags and sets 0 to 7, a quarter writes
      for (int n = 0; n < 300; n++) begin
         rnd = next_rand();
         adr = {18'h0, rnd[27:24], 3'b000, rnd[22:20], rnd[19:18], 2'b00};
         if (rnd[31:30] == 2'b11) begin
            cpu_access(adr, 1'b1, next_rand(), rnd[3:0]);
         end else begin
            cpu_access(adr, 1'b0, '0, '0);
         end
      end
      // Miss counter against bus refills, then cleared
      cfg_access(1'b0, `DC_CFG_MISS_OFS, '0);
      cfg_access(1'b1, `DC_CFG_MISS_OFS, '0);
      cfg_access(1'b0, `DC_CFG_MISS_OFS, '0);
      // Invalidate set 8, so A and B refill again
      cfg_access(1'b1, `DC_CFG_INVAL_OFS, 32'h0080);
      cpu_access(32'h0080, 1'b0, '0, '0);
      cpu_access(32'h048C, 1'b0, '0, '0);
      cfg_access(1'b0, `DC_CFG_MISS_OFS, '0);
      $display("Simulation passed");
      $finish;
   end

endmodule
